// File: src/rob_pkg.sv
package rob_pkg;

  localparam int DISP_SIZE    = 2;
  localparam int CMT_BLK_SIZE = 8;
  localparam int CMT_BLK_W    = 3;
  localparam int DONE_PORTS   = 2;
  localparam int RNID_W       = 6;
  localparam int REGIDX_W     = 5;
  localparam int VADDR_W      = 32;
  localparam int EXC_W        = 4;

  // Exception causes, mcause numbering
  localparam logic [EXC_W-1:0] EXC_INST_MISALIGN = EXC_W'(0);
  localparam logic [EXC_W-1:0] EXC_ILLEGAL_INST  = EXC_W'(2);
  localparam logic [EXC_W-1:0] EXC_BREAKPOINT    = EXC_W'(3);
  localparam logic [EXC_W-1:0] EXC_LOAD_FAULT    = EXC_W'(5);
  localparam logic [EXC_W-1:0] EXC_STORE_FAULT   = EXC_W'(7);
  localparam logic [EXC_W-1:0] EXC_ECALL_M       = EXC_W'(11);

  typedef struct packed {
    logic [VADDR_W-EXC_W-1:0] tval;
    logic [EXC_W-1:0]         cause;
  } exc_info_t;

  // Same word, read by the report's flag
  typedef union packed {
    logic [VADDR_W-1:0] br_target;
    exc_info_t          exc;
  } done_payload_u;

endpackage

// File: src/rob_ptr.sv
module rob_ptr (
  input  logic                          i_clk,
  input  logic                          i_reset_n,
  input  logic                          i_in_valid,
  input  logic                          i_out_valid,
  output logic [rob_pkg::CMT_BLK_W-1:0] o_in_ptr,
  output logic [rob_pkg::CMT_BLK_W-1:0] o_out_ptr,
  output logic                          o_full,
  output logic                          o_empty
);
  import rob_pkg::*;

  logic [CMT_BLK_W:0] r_count;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_in_ptr  <= '0;
      o_out_ptr <= '0;
      r_count   <= '0;
    end else begin
      if (i_in_valid) o_in_ptr <= o_in_ptr + 1'b1;   // Wraps at the power of two
      if (i_out_valid) o_out_ptr <= o_out_ptr + 1'b1;
      if (i_in_valid && !i_out_valid) begin
        r_count <= r_count + 1'b1;
      end else if (!i_in_valid && i_out_valid) begin
        r_count <= r_count - 1'b1;
      end
    end
  end

  assign o_full  = (r_count == (CMT_BLK_W + 1)'(CMT_BLK_SIZE));
  assign o_empty = (r_count == '0);

endmodule

// File: src/rob_entry.sv
module rob_entry #(
  parameter int ID = 0
) (
  input  logic                                  i_clk,
  input  logic                                  i_reset_n,
  input  logic                                  i_load_valid,
  input  logic [rob_pkg::DISP_SIZE-1:0]         i_disp_lane_valid,
  input  logic [rob_pkg::DISP_SIZE-1:0]         i_disp_rd_valid,
  input  logic [rob_pkg::REGIDX_W-1:0]          i_disp_rd_regidx [rob_pkg::DISP_SIZE],
  input  logic [rob_pkg::RNID_W-1:0]            i_disp_rd_rnid [rob_pkg::DISP_SIZE],
  input  logic [rob_pkg::RNID_W-1:0]            i_disp_rd_old_rnid [rob_pkg::DISP_SIZE],
  input  logic [rob_pkg::DONE_PORTS-1:0]        i_done_valid,
  input  logic [rob_pkg::CMT_BLK_W-1:0]         i_done_cmt_id [rob_pkg::DONE_PORTS],
  input  logic [$clog2(rob_pkg::DISP_SIZE)-1:0] i_done_lane [rob_pkg::DONE_PORTS],
  input  logic [rob_pkg::DONE_PORTS-1:0]        i_done_br_mispred,
  input  logic [rob_pkg::DONE_PORTS-1:0]        i_done_except,
  input  rob_pkg::done_payload_u                i_done_payload [rob_pkg::DONE_PORTS],
  input  logic                                  i_kill,
  input  logic                                  i_commit_finish,
  output logic                                  o_valid,
  output logic                                  o_dead,
  output logic                                  o_all_done,
  output logic [rob_pkg::DISP_SIZE-1:0]         o_lane_valid,
  output logic [rob_pkg::DISP_SIZE-1:0]         o_br_mispred,
  output logic [rob_pkg::DISP_SIZE-1:0]         o_except,
  output rob_pkg::done_payload_u                o_payload [rob_pkg::DISP_SIZE],
  output logic [rob_pkg::DISP_SIZE-1:0]         o_rd_valid,
  output logic [rob_pkg::REGIDX_W-1:0]          o_rd_regidx [rob_pkg::DISP_SIZE],
  output logic [rob_pkg::RNID_W-1:0]            o_rd_rnid [rob_pkg::DISP_SIZE],
  output logic [rob_pkg::RNID_W-1:0]            o_rd_old_rnid [rob_pkg::DISP_SIZE]
);
  import rob_pkg::*;

  logic [DISP_SIZE-1:0] r_done;
  logic [DISP_SIZE-1:0] w_done_set;
  logic [DISP_SIZE-1:0] w_br_set;
  logic [DISP_SIZE-1:0] w_exc_set;
  done_payload_u        w_payload_in [DISP_SIZE];

  // Match every report port against each lane of this block
  always_comb begin
    w_done_set = '0;
    w_br_set   = '0;
    w_exc_set  = '0;
    for (int l = 0; l < DISP_SIZE; l++) begin
      w_payload_in[l] = '0;
      for (int p = 0; p < DONE_PORTS; p++) begin
        if (i_done_valid[p] && i_done_cmt_id[p] == CMT_BLK_W'(ID) &&
            int'(i_done_lane[p]) == l) begin
          w_done_set[l]   = 1'b1;
          w_br_set[l]     = i_done_br_mispred[p];
          w_exc_set[l]    = i_done_except[p];
          w_payload_in[l] = i_done_payload[p];
        end
      end
    end
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_valid      <= 1'b0;
      o_dead       <= 1'b0;
      o_lane_valid <= '0;
      r_done       <= '0;
      o_br_mispred <= '0;
      o_except     <= '0;
    end else if (i_commit_finish) begin
      o_valid <= 1'b0;
      o_dead  <= 1'b0;
    end else if (i_load_valid) begin
      o_valid      <= 1'b1;
      o_dead       <= 1'b0;
      o_lane_valid <= i_disp_lane_valid;
      r_done       <= '0;
      o_br_mispred <= '0;
      o_except     <= '0;
    end else if (o_valid) begin
      if (i_kill) o_dead <= 1'b1;
      r_done       <= r_done | w_done_set;
      o_br_mispred <= o_br_mispred | w_br_set;
      o_except     <= o_except | w_exc_set;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_load_valid) begin
      o_rd_valid    <= i_disp_rd_valid;
      o_rd_regidx   <= i_disp_rd_regidx;
      o_rd_rnid     <= i_disp_rd_rnid;
      o_rd_old_rnid <= i_disp_rd_old_rnid;
    end
    for (int l = 0; l < DISP_SIZE; l++) begin
      if (w_done_set[l]) o_payload[l] <= w_payload_in[l];
    end
  end

  // A dead block counts as done
  assign o_all_done = o_valid & (o_dead | ((r_done & o_lane_valid) == o_lane_valid));

endmodule

// File: src/rob_commit_sel.sv
module rob_commit_sel (
  input  logic [rob_pkg::DISP_SIZE-1:0] i_lane_valid,
  input  logic [rob_pkg::DISP_SIZE-1:0] i_br_mispred,
  input  logic [rob_pkg::DISP_SIZE-1:0] i_except,
  input  rob_pkg::done_payload_u        i_payload [rob_pkg::DISP_SIZE],
  output logic                          o_flush,
  output logic [rob_pkg::VADDR_W-1:0]   o_flush_pc,
  output logic                          o_except,
  output logic [rob_pkg::EXC_W-1:0]     o_except_cause,
  output logic [rob_pkg::DISP_SIZE-1:0] o_dead_lanes
);
  import rob_pkg::*;

  logic w_found;

  // Lowest flushing lane wins, everything above it dies
  always_comb begin
    w_found        = 1'b0;
    o_flush_pc     = '0;
    o_except       = 1'b0;
    o_except_cause = '0;
    o_dead_lanes   = '0;
    for (int l = 0; l < DISP_SIZE; l++) begin
      if (w_found) begin
        o_dead_lanes[l] = i_lane_valid[l];
      end else if (i_lane_valid[l] && (i_br_mispred[l] || i_except[l])) begin
        w_found  = 1'b1;
        o_except = i_except[l];
        if (i_br_mispred[l]) begin
          o_flush_pc = i_payload[l].br_target;
        end else begin
          o_except_cause = i_payload[l].exc.cause;
        end
      end
    end
  end

  assign o_flush = w_found;

endmodule

// File: src/rob.sv
module rob (
  input  logic                                  i_clk,
  input  logic                                  i_reset_n,
  input  logic                                  i_disp_valid,
  output logic                                  o_disp_ready,
  input  logic [rob_pkg::DISP_SIZE-1:0]         i_disp_lane_valid,
  input  logic [rob_pkg::DISP_SIZE-1:0]         i_disp_rd_valid,
  input  logic [rob_pkg::REGIDX_W-1:0]          i_disp_rd_regidx [rob_pkg::DISP_SIZE],
  input  logic [rob_pkg::RNID_W-1:0]            i_disp_rd_rnid [rob_pkg::DISP_SIZE],
  input  logic [rob_pkg::RNID_W-1:0]            i_disp_rd_old_rnid [rob_pkg::DISP_SIZE],
  output logic [rob_pkg::CMT_BLK_W-1:0]         o_new_cmt_id,
  input  logic [rob_pkg::DONE_PORTS-1:0]        i_done_valid,
  input  logic [rob_pkg::CMT_BLK_W-1:0]         i_done_cmt_id [rob_pkg::DONE_PORTS],
  input  logic [$clog2(rob_pkg::DISP_SIZE)-1:0] i_done_lane [rob_pkg::DONE_PORTS],
  input  logic [rob_pkg::DONE_PORTS-1:0]        i_done_br_mispred,
  input  logic [rob_pkg::DONE_PORTS-1:0]        i_done_except,
  input  rob_pkg::done_payload_u                i_done_payload [rob_pkg::DONE_PORTS],
  output logic                                  o_cmt_valid,
  output logic [rob_pkg::CMT_BLK_W-1:0]         o_cmt_id,
  output logic [rob_pkg::DISP_SIZE-1:0]         o_cmt_lane_valid,
  output logic                                  o_cmt_flush,
  output logic [rob_pkg::VADDR_W-1:0]           o_cmt_flush_pc,
  output logic                                  o_cmt_except,
  output logic [rob_pkg::EXC_W-1:0]             o_cmt_except_cause,
  output logic [rob_pkg::DISP_SIZE-1:0]         o_cmt_dead_lanes,
  output logic                                  o_cmt_all_dead,
  output logic [rob_pkg::DISP_SIZE-1:0]         o_cmt_rd_valid,
  output logic [rob_pkg::REGIDX_W-1:0]          o_cmt_rd_regidx [rob_pkg::DISP_SIZE],
  output logic [rob_pkg::RNID_W-1:0]            o_cmt_rd_rnid [rob_pkg::DISP_SIZE],
  output logic [rob_pkg::RNID_W-1:0]            o_cmt_rd_old_rnid [rob_pkg::DISP_SIZE]
);
  import rob_pkg::*;

  logic [CMT_BLK_W-1:0]    w_in_ptr;
  logic [CMT_BLK_W-1:0]    w_out_ptr;
  logic                    w_full;
  logic                    w_empty;
  logic [CMT_BLK_SIZE-1:0] w_valid;
  logic [CMT_BLK_SIZE-1:0] w_dead;
  logic [CMT_BLK_SIZE-1:0] w_all_done;
  logic [DISP_SIZE-1:0]    w_lane_valid [CMT_BLK_SIZE];
  logic [DISP_SIZE-1:0]    w_br_mispred [CMT_BLK_SIZE];
  logic [DISP_SIZE-1:0]    w_except [CMT_BLK_SIZE];
  logic [DISP_SIZE-1:0]    w_rd_valid [CMT_BLK_SIZE];
  done_payload_u           w_payload [CMT_BLK_SIZE][DISP_SIZE];
  logic [REGIDX_W-1:0]     w_rd_regidx [CMT_BLK_SIZE][DISP_SIZE];
  logic [RNID_W-1:0]       w_rd_rnid [CMT_BLK_SIZE][DISP_SIZE];
  logic [RNID_W-1:0]       w_rd_old_rnid [CMT_BLK_SIZE][DISP_SIZE];
  logic                    w_disp_accept;
  logic                    r_killing;
  logic                    w_killing;
  logic                    w_sel_flush;
  logic                    w_sel_except;
  logic [DISP_SIZE-1:0]    w_sel_dead;

  assign w_disp_accept = i_disp_valid & o_disp_ready;

  rob_ptr u_ptr (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_in_valid  (w_disp_accept),
    .i_out_valid (o_cmt_valid),
    .o_in_ptr    (w_in_ptr),
    .o_out_ptr   (w_out_ptr),
    .o_full      (w_full),
    .o_empty     (w_empty)
  );

  for (genvar c = 0; c < CMT_BLK_SIZE; c++) begin : g_entry
    rob_entry #(.ID(c)) u_entry (
      .i_clk              (i_clk),
      .i_reset_n          (i_reset_n),
      .i_load_valid       (w_disp_accept & (w_in_ptr == CMT_BLK_W'(c))),
      .i_disp_lane_valid  (i_disp_lane_valid),
      .i_disp_rd_valid    (i_disp_rd_valid),
      .i_disp_rd_regidx   (i_disp_rd_regidx),
      .i_disp_rd_rnid     (i_disp_rd_rnid),
      .i_disp_rd_old_rnid (i_disp_rd_old_rnid),
      .i_done_valid       (i_done_valid),
      .i_done_cmt_id      (i_done_cmt_id),
      .i_done_lane        (i_done_lane),
      .i_done_br_mispred  (i_done_br_mispred),
      .i_done_except      (i_done_except),
      .i_done_payload     (i_done_payload),
      .i_kill             (o_cmt_flush & (w_out_ptr != CMT_BLK_W'(c))),  // Everything but the head
      .i_commit_finish    (o_cmt_valid & (w_out_ptr == CMT_BLK_W'(c))),
      .o_valid            (w_valid[c]),
      .o_dead             (w_dead[c]),
      .o_all_done         (w_all_done[c]),
      .o_lane_valid       (w_lane_valid[c]),
      .o_br_mispred       (w_br_mispred[c]),
      .o_except           (w_except[c]),
      .o_payload          (w_payload[c]),
      .o_rd_valid         (w_rd_valid[c]),
      .o_rd_regidx        (w_rd_regidx[c]),
      .o_rd_rnid          (w_rd_rnid[c]),
      .o_rd_old_rnid      (w_rd_old_rnid[c])
    );
  end

  rob_commit_sel u_sel (
    .i_lane_valid   (w_lane_valid[w_out_ptr]),
    .i_br_mispred   (w_br_mispred[w_out_ptr]),
    .i_except       (w_except[w_out_ptr]),
    .i_payload      (w_payload[w_out_ptr]),
    .o_flush        (w_sel_flush),
    .o_flush_pc     (o_cmt_flush_pc),
    .o_except       (w_sel_except),
    .o_except_cause (o_cmt_except_cause),
    .o_dead_lanes   (w_sel_dead)
  );

  // Draining younger blocks after a flush
  assign w_killing = r_killing & w_valid[w_out_ptr] & w_dead[w_out_ptr];

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_killing <= 1'b0;
    end else if (o_cmt_flush && w_valid[CMT_BLK_W'(w_out_ptr + 1'b1)]) begin
      r_killing <= 1'b1;
    end else if (r_killing && !(w_valid[w_out_ptr] && w_dead[w_out_ptr])) begin
      r_killing <= 1'b0;
    end
  end

  assign o_disp_ready     = ~w_full & ~w_killing;
  assign o_new_cmt_id     = w_in_ptr;
  assign o_cmt_valid      = ~w_empty & w_all_done[w_out_ptr];
  assign o_cmt_id         = w_out_ptr;
  assign o_cmt_lane_valid = w_lane_valid[w_out_ptr];
  assign o_cmt_flush      = o_cmt_valid & w_sel_flush & ~w_killing;
  assign o_cmt_except     = o_cmt_flush & w_sel_except;
  assign o_cmt_dead_lanes = w_killing ? w_lane_valid[w_out_ptr] : w_sel_dead;
  assign o_cmt_all_dead   = w_killing;

  assign o_cmt_rd_valid    = w_rd_valid[w_out_ptr];
  assign o_cmt_rd_regidx   = w_rd_regidx[w_out_ptr];
  assign o_cmt_rd_rnid     = w_rd_rnid[w_out_ptr];
  assign o_cmt_rd_old_rnid = w_rd_old_rnid[w_out_ptr];

endmodule

// File: src/rob_arch_map.sv
module rob_arch_map (
  input  logic                          i_clk,
  input  logic                          i_reset_n,
  input  logic                          i_cmt_valid,
  input  logic [rob_pkg::DISP_SIZE-1:0] i_cmt_lane_valid,
  input  logic [rob_pkg::DISP_SIZE-1:0] i_cmt_dead_lanes,
  input  logic                          i_cmt_all_dead,
  input  logic [rob_pkg::DISP_SIZE-1:0] i_cmt_rd_valid,
  input  logic [rob_pkg::REGIDX_W-1:0]  i_cmt_rd_regidx [rob_pkg::DISP_SIZE],
  input  logic [rob_pkg::RNID_W-1:0]    i_cmt_rd_rnid [rob_pkg::DISP_SIZE],
  input  logic [rob_pkg::RNID_W-1:0]    i_cmt_rd_old_rnid [rob_pkg::DISP_SIZE],
  input  logic [rob_pkg::REGIDX_W-1:0]  i_map_regidx,
  output logic [rob_pkg::RNID_W-1:0]    o_map_rnid,
  output logic [rob_pkg::DISP_SIZE-1:0] o_free_valid,
  output logic [rob_pkg::RNID_W-1:0]    o_free_rnid [rob_pkg::DISP_SIZE]
);
  import rob_pkg::*;

  logic [RNID_W-1:0]    r_map [2**REGIDX_W];
  logic [DISP_SIZE-1:0] w_killed;
  logic [DISP_SIZE-1:0] w_live;
  logic [DISP_SIZE-1:0] w_dead;

  assign w_killed = i_cmt_dead_lanes | {DISP_SIZE{i_cmt_all_dead}};
  assign w_live   = {DISP_SIZE{i_cmt_valid}} & i_cmt_lane_valid & i_cmt_rd_valid & ~w_killed;
  assign w_dead   = {DISP_SIZE{i_cmt_valid}} & i_cmt_lane_valid & i_cmt_rd_valid & w_killed;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int i = 0; i < 2**REGIDX_W; i++) r_map[i] <= RNID_W'(i);
    end else begin
      // Later lane overrides on the same index
      for (int l = 0; l < DISP_SIZE; l++) begin
        if (w_live[l]) r_map[i_cmt_rd_regidx[l]] <= i_cmt_rd_rnid[l];
      end
    end
  end

  assign o_map_rnid   = r_map[i_map_regidx];
  assign o_free_valid = w_live | w_dead;

  for (genvar l = 0; l < DISP_SIZE; l++) begin : g_free
    assign o_free_rnid[l] = w_dead[l] ? i_cmt_rd_rnid[l] : i_cmt_rd_old_rnid[l];  // Dead frees new
  end

endmodule

// File: src/rob_top.sv
module rob_top (
  input  logic                                  i_clk,
  input  logic                                  i_reset_n,
  input  logic                                  i_disp_valid,
  output logic                                  o_disp_ready,
  input  logic [rob_pkg::VADDR_W-1:0]           i_disp_pc,
  input  logic [rob_pkg::DISP_SIZE-1:0]         i_disp_lane_valid,
  input  logic [rob_pkg::DISP_SIZE-1:0]         i_disp_rd_valid,
  input  logic [rob_pkg::REGIDX_W-1:0]          i_disp_rd_regidx [rob_pkg::DISP_SIZE],
  input  logic [rob_pkg::RNID_W-1:0]            i_disp_rd_rnid [rob_pkg::DISP_SIZE],
  input  logic [rob_pkg::RNID_W-1:0]            i_disp_rd_old_rnid [rob_pkg::DISP_SIZE],
  output logic [rob_pkg::CMT_BLK_W-1:0]         o_new_cmt_id,
  input  logic [rob_pkg::DONE_PORTS-1:0]        i_done_valid,
  input  logic [rob_pkg::CMT_BLK_W-1:0]         i_done_cmt_id [rob_pkg::DONE_PORTS],
  input  logic [$clog2(rob_pkg::DISP_SIZE)-1:0] i_done_lane [rob_pkg::DONE_PORTS],
  input  logic [rob_pkg::DONE_PORTS-1:0]        i_done_br_mispred,
  input  logic [rob_pkg::DONE_PORTS-1:0]        i_done_except,
  input  rob_pkg::done_payload_u                i_done_payload [rob_pkg::DONE_PORTS],
  output logic                                  o_cmt_valid,
  output logic [rob_pkg::CMT_BLK_W-1:0]         o_cmt_id,
  output logic [rob_pkg::DISP_SIZE-1:0]         o_cmt_lane_valid,
  output logic                                  o_cmt_flush,
  output logic [rob_pkg::VADDR_W-1:0]           o_cmt_flush_pc,
  output logic                                  o_cmt_except,
  output logic [rob_pkg::EXC_W-1:0]             o_cmt_except_cause,
  output logic [rob_pkg::DISP_SIZE-1:0]         o_cmt_dead_lanes,
  output logic                                  o_cmt_all_dead,
  input  logic [rob_pkg::REGIDX_W-1:0]          i_map_regidx,
  output logic [rob_pkg::RNID_W-1:0]            o_map_rnid,
  output logic [rob_pkg::DISP_SIZE-1:0]         o_free_valid,
  output logic [rob_pkg::RNID_W-1:0]            o_free_rnid [rob_pkg::DISP_SIZE]
);
  import rob_pkg::*;

  logic [DISP_SIZE-1:0] w_cmt_rd_valid;
  logic [REGIDX_W-1:0]  w_cmt_rd_regidx [DISP_SIZE];
  logic [RNID_W-1:0]    w_cmt_rd_rnid [DISP_SIZE];
  logic [RNID_W-1:0]    w_cmt_rd_old_rnid [DISP_SIZE];

  rob u_rob (
    .i_clk, .i_reset_n, .i_disp_valid, .o_disp_ready,
    .i_disp_lane_valid, .i_disp_rd_valid, .i_disp_rd_regidx,
    .i_disp_rd_rnid, .i_disp_rd_old_rnid, .o_new_cmt_id,
    .i_done_valid, .i_done_cmt_id, .i_done_lane,
    .i_done_br_mispred, .i_done_except, .i_done_payload,
    .o_cmt_valid, .o_cmt_id, .o_cmt_lane_valid, .o_cmt_flush, .o_cmt_flush_pc,
    .o_cmt_except, .o_cmt_except_cause, .o_cmt_dead_lanes, .o_cmt_all_dead,
    .o_cmt_rd_valid    (w_cmt_rd_valid),
    .o_cmt_rd_regidx   (w_cmt_rd_regidx),
    .o_cmt_rd_rnid     (w_cmt_rd_rnid),
    .o_cmt_rd_old_rnid (w_cmt_rd_old_rnid)
  );

  rob_arch_map u_arch_map (
    .i_clk, .i_reset_n,
    .i_cmt_valid       (o_cmt_valid),
    .i_cmt_lane_valid  (o_cmt_lane_valid),
    .i_cmt_dead_lanes  (o_cmt_dead_lanes),
    .i_cmt_all_dead    (o_cmt_all_dead),
    .i_cmt_rd_valid    (w_cmt_rd_valid),
    .i_cmt_rd_regidx   (w_cmt_rd_regidx),
    .i_cmt_rd_rnid     (w_cmt_rd_rnid),
    .i_cmt_rd_old_rnid (w_cmt_rd_old_rnid),
    .i_map_regidx, .o_map_rnid, .o_free_valid, .o_free_rnid
  );

endmodule

// File: tests/rob_tb.sv
module rob_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import rob_pkg::*;

  localparam int K_OK  = 0;
  localparam int K_MIS = 1;
  localparam int K_EXC = 2;

  typedef struct packed {
    logic                 v;
    logic [CMT_BLK_W-1:0] id;
    logic                 lane;
    logic [1:0]           kind;
    logic [VADDR_W-1:0]   pay;
  } rep_t;

  typedef struct packed {
    logic                 dv;
    logic [DISP_SIZE-1:0] lv;
    logic [DISP_SIZE-1:0] rv;
    rep_t                 r0;
    rep_t                 r1;
    int                   exp_id;  // -1 for no commit
  } row_t;

  // Reference view of one commit block
  typedef struct packed {
    logic [CMT_BLK_W-1:0]               id;
    logic [DISP_SIZE-1:0]               lv;
    logic [DISP_SIZE-1:0]               rv;
    logic [DISP_SIZE-1:0]               done;
    logic [DISP_SIZE-1:0]               mis;
    logic [DISP_SIZE-1:0]               exc;
    logic                               dead;
    logic [DISP_SIZE-1:0][REGIDX_W-1:0] regidx;
    logic [DISP_SIZE-1:0][RNID_W-1:0]   rnid;
    logic [DISP_SIZE-1:0][RNID_W-1:0]   old;
    logic [DISP_SIZE-1:0][VADDR_W-1:0]  pay;
  } blk_t;

  localparam rep_t NO_REP = '0;

  logic                         i_clk;
  logic                         i_reset_n;
  logic                         i_disp_valid;
  logic                         o_disp_ready;
  logic [VADDR_W-1:0]           i_disp_pc;
  logic [DISP_SIZE-1:0]         i_disp_lane_valid;
  logic [DISP_SIZE-1:0]         i_disp_rd_valid;
  logic [REGIDX_W-1:0]          i_disp_rd_regidx [DISP_SIZE];
  logic [RNID_W-1:0]            i_disp_rd_rnid [DISP_SIZE];
  logic [RNID_W-1:0]            i_disp_rd_old_rnid [DISP_SIZE];
  logic [CMT_BLK_W-1:0]         o_new_cmt_id;
  logic [DONE_PORTS-1:0]        i_done_valid;
  logic [CMT_BLK_W-1:0]         i_done_cmt_id [DONE_PORTS];
  logic [$clog2(DISP_SIZE)-1:0] i_done_lane [DONE_PORTS];
  logic [DONE_PORTS-1:0]        i_done_br_mispred;
  logic [DONE_PORTS-1:0]        i_done_except;
  done_payload_u                i_done_payload [DONE_PORTS];
  logic                         o_cmt_valid;
  logic [CMT_BLK_W-1:0]         o_cmt_id;
  logic [DISP_SIZE-1:0]         o_cmt_lane_valid;
  logic                         o_cmt_flush;
  logic [VADDR_W-1:0]           o_cmt_flush_pc;
  logic                         o_cmt_except;
  logic [EXC_W-1:0]             o_cmt_except_cause;
  logic [DISP_SIZE-1:0]         o_cmt_dead_lanes;
  logic                         o_cmt_all_dead;
  logic [REGIDX_W-1:0]          i_map_regidx;
  logic [RNID_W-1:0]            o_map_rnid;
  logic [DISP_SIZE-1:0]         o_free_valid;
  logic [RNID_W-1:0]            o_free_rnid [DISP_SIZE];

  blk_t                 mq[$];
  row_t                 tbl[$];
  logic [RNID_W-1:0]    amap [2**REGIDX_W];
  logic [CMT_BLK_W-1:0] next_id;
  logic                 kill;
  logic [31:0]          seed = 32'h4589beaf;
  int                   cycles = 0;

  rob_top DUT (.*);

  initial begin
    i_clk = 1'b0;
    forever #5 i_clk = ~i_clk;
  end

  always @(posedge i_clk) begin
    cycles <= cycles + 1;
    if (cycles > tbl.size() * 20 + 100) begin
      $display("run timed out after %0d cycles without finishing the table", cycles);
      $display("Test failed");
      $fatal(1, "timeout");
    end
  end

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic rep_t done_rep(input int id, input int lane, input int kind,
                                    input logic [VADDR_W-1:0] pay);
    rep_t rp;
    rp.v    = 1'b1;
    rp.id   = CMT_BLK_W'(id);
    rp.lane = lane[0];
    rp.kind = kind[1:0];
    rp.pay  = pay;
    return rp;
  endfunction

  task automatic add_row(input logic dv, input logic [DISP_SIZE-1:0] lv,
                         input logic [DISP_SIZE-1:0] rv, input rep_t r0, input rep_t r1,
                         input int exp_id);
    tbl.push_back('{dv, lv, rv, r0, r1, exp_id});
  endtask

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s is %0h, expected %0h", $time, name, got, exp);
      $display("Test failed");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic idle_inputs();
    i_disp_valid      = 1'b0;
    i_disp_pc         = '0;
    i_disp_lane_valid = '0;
    i_disp_rd_valid   = '0;
    i_done_valid      = '0;
    i_done_br_mispred = '0;
    i_done_except     = '0;
    i_map_regidx      = '0;
    for (int l = 0; l < DISP_SIZE; l++) begin
      i_disp_rd_regidx[l]   = '0;
      i_disp_rd_rnid[l]     = '0;
      i_disp_rd_old_rnid[l] = '0;
    end
    for (int p = 0; p < DONE_PORTS; p++) begin
      i_done_cmt_id[p]  = '0;
      i_done_lane[p]    = '0;
      i_done_payload[p] = '0;
    end
  endtask

  task automatic drive_report(input int p, input rep_t rp);
    i_done_valid[p]      = rp.v;
    i_done_cmt_id[p]     = rp.id;
    i_done_lane[p]       = rp.lane;
    i_done_br_mispred[p] = rp.v && rp.kind == 2'(K_MIS);
    i_done_except[p]     = rp.v && rp.kind == 2'(K_EXC);
    i_done_payload[p]    = rp.pay;
  endtask

  task automatic drive_row(input row_t r, input logic hold);
    logic [31:0] rnd;
    i_disp_valid      = r.dv;
    i_disp_lane_valid = r.lv;
    i_disp_rd_valid   = r.rv;
    if (!hold) begin  // Held group keeps its registers
      i_disp_pc = next_rand();
      for (int l = 0; l < DISP_SIZE; l++) begin
        rnd = next_rand();
        i_disp_rd_regidx[l]   = rnd[20:16];
        i_disp_rd_rnid[l]     = rnd[13:8];
        i_disp_rd_old_rnid[l] = rnd[29:24];
      end
    end
    rnd = next_rand();
    drive_report(rnd[16] ? 1 : 0, r.r0);  // Random port order
    drive_report(rnd[16] ? 0 : 1, r.r1);
    i_map_regidx = rnd[28:24];
  endtask

  task automatic sweep_map();
    for (int i = 0; i < 2**REGIDX_W; i++) begin
      @(negedge i_clk);
      i_map_regidx = REGIDX_W'(i);
      #1;
      check("o_map_rnid", o_map_rnid, amap[i]);
    end
  endtask

  // Expected outputs of this cycle, then the model's register updates at the edge
  task automatic check_cycle(input row_t r, output logic accepted);
    blk_t                 h;
    blk_t                 b;
    rep_t                 rp [DONE_PORTS];
    logic                 killing;
    logic                 cmt;
    logic                 flush;
    logic                 ready;
    logic [DISP_SIZE-1:0] dead;
    int                   sel;
    h     = '0;
    sel   = 0;
    rp[0] = r.r0;
    rp[1] = r.r1;
    if (mq.size() > 0) h = mq[0];
    killing  = kill && mq.size() > 0 && h.dead;
    cmt      = mq.size() > 0 && (h.dead || (h.done & h.lv) == h.lv);
    ready    = mq.size() < CMT_BLK_SIZE && !killing;
    accepted = i_disp_valid && ready;
    flush    = 1'b0;
    dead     = '0;
    for (int l = 0; l < DISP_SIZE; l++) begin
      if (flush) begin
        dead[l] = h.lv[l];
      end else if (h.lv[l] && (h.mis[l] || h.exc[l])) begin
        flush = 1'b1;
        sel   = l;
      end
    end
    if (killing) begin
      flush = 1'b0;
      dead  = h.lv;
    end
    flush = flush && cmt;
    check("o_disp_ready", o_disp_ready, ready);
    check("o_new_cmt_id", o_new_cmt_id, next_id);
    check("o_cmt_valid", o_cmt_valid, cmt);
    check("o_cmt_id (table)", o_cmt_valid ? int'(o_cmt_id) : -1, r.exp_id);
    check("o_cmt_flush", o_cmt_flush, flush);
    if (cmt) begin
      check("o_cmt_lane_valid", o_cmt_lane_valid, h.lv);
      check("o_cmt_all_dead", o_cmt_all_dead, killing);
      check("o_cmt_dead_lanes", o_cmt_dead_lanes, dead);
      check("o_cmt_except", o_cmt_except, flush && h.exc[sel]);
    end
    if (flush) begin
      check("o_cmt_flush_pc", o_cmt_flush_pc, h.mis[sel] ? h.pay[sel] : '0);
      if (h.exc[sel]) check("o_cmt_except_cause", o_cmt_except_cause, h.pay[sel][EXC_W-1:0]);
    end
    for (int l = 0; l < DISP_SIZE; l++) begin
      check("o_free_valid", o_free_valid[l], cmt && h.lv[l] && h.rv[l]);
      if (cmt && h.lv[l] && h.rv[l]) begin
        check("o_free_rnid", o_free_rnid[l], dead[l] ? h.rnid[l] : h.old[l]);
      end
    end
    check("o_map_rnid", o_map_rnid, amap[i_map_regidx]);

    if (cmt) begin
      for (int l = 0; l < DISP_SIZE; l++) begin
        if (h.lv[l] && h.rv[l] && !dead[l]) amap[h.regidx[l]] = h.rnid[l];  // Lane 1 last
      end
      mq.delete(0);
    end
    if (flush && mq.size() > 0) kill = 1'b1;
    else if (!killing) kill = 1'b0;
    for (int i = 0; i < mq.size(); i++) begin
      b = mq[i];
      if (flush) b.dead = 1'b1;
      for (int p = 0; p < DONE_PORTS; p++) begin
        if (rp[p].v && rp[p].id == b.id) begin
          b.done[rp[p].lane] = 1'b1;
          b.mis[rp[p].lane]  = b.mis[rp[p].lane] | (rp[p].kind == 2'(K_MIS));
          b.exc[rp[p].lane]  = b.exc[rp[p].lane] | (rp[p].kind == 2'(K_EXC));
          b.pay[rp[p].lane]  = rp[p].pay;
        end
      end
      mq[i] = b;
    end
    if (accepted) begin
      b    = '0;
      b.id = next_id;
      b.lv = i_disp_lane_valid;
      b.rv = i_disp_rd_valid;
      for (int l = 0; l < DISP_SIZE; l++) begin
        b.regidx[l] = i_disp_rd_regidx[l];
        b.rnid[l]   = i_disp_rd_rnid[l];
        b.old[l]    = i_disp_rd_old_rnid[l];
      end
      mq.push_back(b);
      next_id = next_id + 1'b1;
    end
  endtask

  task automatic build_table();
    // Four groups, completed youngest first
    add_row(1, 2'b11, 2'b11, NO_REP, NO_REP, -1);
    add_row(1, 2'b01, 2'b01, NO_REP, NO_REP, -1);
    add_row(1, 2'b11, 2'b10, NO_REP, NO_REP, -1);
    add_row(1, 2'b11, 2'b11, NO_REP, NO_REP, -1);
    add_row(0, 2'b00, 2'b00, done_rep(3, 0, K_OK, 0), done_rep(3, 1, K_OK, 0), -1);
    add_row(0, 2'b00, 2'b00, done_rep(2, 0, K_OK, 0), done_rep(2, 1, K_OK, 0), -1);
    add_row(0, 2'b00, 2'b00, done_rep(1, 0, K_OK, 0), NO_REP, -1);
    add_row(0, 2'b00, 2'b00, done_rep(0, 0, K_OK, 0), done_rep(0, 1, K_OK, 0), -1);
    for (int id = 0; id < 4; id++) add_row(0, 2'b00, 2'b00, NO_REP, NO_REP, id);
    // Mispredict on lane 0 of block 4, blocks 5 and 6 drain as dead
    add_row(1, 2'b11, 2'b11, NO_REP, NO_REP, -1);
    add_row(1, 2'b11, 2'b01, NO_REP, NO_REP, -1);
    add_row(1, 2'b01, 2'b01, NO_REP, NO_REP, -1);
    add_row(0, 2'b00, 2'b00, done_rep(5, 0, K_OK, 0), done_rep(6, 0, K_OK, 0), -1);
    add_row(0, 2'b00, 2'b00, done_rep(4, 0, K_MIS, 32'h8000_1a40), done_rep(4, 1, K_OK, 0), -1);
    add_row(0, 2'b00, 2'b00, NO_REP, NO_REP, 4);
    add_row(0, 2'b00, 2'b00, NO_REP, NO_REP, 5);
    add_row(0, 2'b00, 2'b00, NO_REP, NO_REP, 6);
    // Exception on lane 1, later on both lanes
    add_row(1, 2'b11, 2'b11, NO_REP, NO_REP, -1);
    add_row(1, 2'b11, 2'b11, NO_REP, NO_REP, -1);
    add_row(0, 2'b00, 2'b00, done_rep(7, 0, K_OK, 0), done_rep(7, 1, K_EXC, 32'h0000_1232), -1);
    add_row(0, 2'b00, 2'b00, NO_REP, NO_REP, 7);
    add_row(0, 2'b00, 2'b00, NO_REP, NO_REP, 0);
    add_row(1, 2'b11, 2'b11, NO_REP, NO_REP, -1);
    add_row(0, 2'b00, 2'b00, done_rep(1, 0, K_EXC, 32'h0000_0ab5),
            done_rep(1, 1, K_EXC, 32'h0000_0cd7), -1);
    add_row(0, 2'b00, 2'b00, NO_REP, NO_REP, 1);
    // Fill every entry, then one group waits for a free slot
    repeat (8) add_row(1, 2'b11, 2'b11, NO_REP, NO_REP, -1);
    add_row(1, 2'b11, 2'b11, done_rep(2, 0, K_OK, 0), done_rep(2, 1, K_OK, 0), -1);
    add_row(1, 2'b11, 2'b11, NO_REP, NO_REP, 2);
    add_row(1, 2'b11, 2'b11, NO_REP, NO_REP, -1);
    add_row(0, 2'b00, 2'b00, done_rep(3, 0, K_OK, 0), done_rep(3, 1, K_OK, 0), -1);
    add_row(0, 2'b00, 2'b00, NO_REP, NO_REP, 3);
    add_row(0, 2'b00, 2'b00, NO_REP, NO_REP, -1);
  endtask

  initial begin
    logic hold;
    logic accepted;
    idle_inputs();
    i_reset_n = 1'b0;
    kill      = 1'b0;
    next_id   = '0;
    for (int i = 0; i < 2**REGIDX_W; i++) amap[i] = RNID_W'(i);
    build_table();
    repeat (8) @(posedge i_clk);
    @(negedge i_clk);
    i_reset_n = 1'b1;
    #1;
    check("o_cmt_valid", o_cmt_valid, 1'b0);
    check("o_cmt_flush", o_cmt_flush, 1'b0);
    check("o_free_valid", o_free_valid, '0);
    check("o_disp_ready", o_disp_ready, 1'b1);
    sweep_map();  // Identity after reset
    hold = 1'b0;
    foreach (tbl[i]) begin
      @(negedge i_clk);
      drive_row(tbl[i], hold);
      #2;
      check_cycle(tbl[i], accepted);
      hold = i_disp_valid && !accepted;
    end
    @(negedge i_clk);
    idle_inputs();
    sweep_map();
    $display("Test completed successfully");
    $finish;
  end

endmodule

// File: compile.f
src/rob_pkg.sv
src/rob_ptr.sv
src/rob_entry.sv
src/rob_commit_sel.sv
src/rob.sv
src/rob_arch_map.sv
src/rob_top.sv
tests/rob_tb.sv
